//--- src/integral_pkg.sv
`default_nettype none

package integral_pkg;

	////////////////////////////////////////
	// pixel and sample types
	////////////////////////////////////////

	// rgb 3-3-2 as delivered by the video source
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb_t;

	// grey after field sum, max 7 + 7 + 3 fits easily
	typedef logic [7:0] grey_t;

	// one integral entry
	// 320 * 240 * 255 needs 25 bits
	typedef logic [24:0] sum_t;

	////////////////////////////////////////
	// default frame size
	////////////////////////////////////////

	parameter int DEF_IMG_W = 320;
	parameter int DEF_IMG_H = 240;

endpackage

`default_nettype wire

//--- src/sdp_ram.sv
`timescale 1ns/1ps
`default_nettype none

// simple dual port ram, one write port and one registered read port
// same payload type for grey and sum stores
module sdp_ram #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 256
) (
	input wire clk,
	input wire we,
	input wire [$clog2(DEPTH)-1:0] wr_addr,
	input wire payload_t wr_data,
	input wire [$clog2(DEPTH)-1:0] rd_addr,
	output payload_t rd_data
);

	// storage, no reset
	payload_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
		// read before write, same address gives the old word
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- src/frame_capture.sv
`timescale 1ns/1ps
`default_nettype none

module frame_capture #(
	parameter int IMG_W = integral_pkg::DEF_IMG_W,
	parameter int IMG_H = integral_pkg::DEF_IMG_H,
	localparam int X_W = $clog2(IMG_W),
	localparam int Y_W = $clog2(IMG_H),
	localparam int A_W = $clog2(IMG_W * IMG_H)
) (
	input wire clk,
	input wire reset,
	input wire arm,
	input wire pix_valid,
	input wire integral_pkg::rgb_t pix_rgb,
	input wire pix_sof,
	output logic busy,
	output logic cap_valid,
	output integral_pkg::grey_t cap_grey,
	output logic [X_W-1:0] cap_x,
	output logic [Y_W-1:0] cap_y,
	output logic cap_last,
	output logic src_we,
	output logic [A_W-1:0] src_addr,
	output integral_pkg::grey_t src_data
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ARMED,
		S_CAPTURE
	} state_t;

	state_t state;

	// raster position of the next accepted pixel
	logic [X_W-1:0] x_cnt;
	logic [Y_W-1:0] y_cnt;
	logic [A_W-1:0] addr_cnt;

	logic accept;
	logic last_pix;
	logic end_of_row;
	integral_pkg::grey_t grey;

	////////////////////////////////////////
	// accept and grey conversion
	////////////////////////////////////////

	// armed waits for sof, then every strobe counts
	assign accept = pix_valid && ((state == S_ARMED && pix_sof) || state == S_CAPTURE);

	assign end_of_row = (x_cnt == X_W'(IMG_W - 1));
	assign last_pix = end_of_row && (y_cnt == Y_W'(IMG_H - 1));

	// plain unsigned field sum
	assign grey = integral_pkg::grey_t'(pix_rgb.red) +
		integral_pkg::grey_t'(pix_rgb.green) +
		integral_pkg::grey_t'(pix_rgb.blue);

	assign busy = (state != S_IDLE);

	////////////////////////////////////////
	// fsm and raster counters
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			x_cnt <= '0;
			y_cnt <= '0;
			addr_cnt <= '0;
			cap_valid <= 1'b0;
			src_we <= 1'b0;
		end else begin
			cap_valid <= accept;
			src_we <= accept;

			case (state)
				S_IDLE: begin
					// new frame starts at origin
					if (arm) begin
						state <= S_ARMED;
						x_cnt <= '0;
						y_cnt <= '0;
						addr_cnt <= '0;
					end
				end
				default: begin
					// arm ignored while busy
					if (accept) begin
						state <= last_pix ? S_IDLE : S_CAPTURE;
					end
				end
			endcase

			if (accept) begin
				addr_cnt <= addr_cnt + 1'b1;
				if (end_of_row) begin
					x_cnt <= '0;
					y_cnt <= y_cnt + 1'b1;
				end else begin
					x_cnt <= x_cnt + 1'b1;
				end
			end
		end
	end

	// payload, qualified by cap_valid and src_we
	always_ff @(posedge clk) begin
		if (accept) begin
			cap_grey <= grey;
			cap_x <= x_cnt;
			cap_y <= y_cnt;
			cap_last <= last_pix;
			src_addr <= addr_cnt;
			src_data <= grey;
		end
	end

endmodule

`default_nettype wire

//--- src/integral_engine.sv
`timescale 1ns/1ps
`default_nettype none

module integral_engine #(
	parameter int IMG_W = integral_pkg::DEF_IMG_W,
	parameter int IMG_H = integral_pkg::DEF_IMG_H,
	localparam int X_W = $clog2(IMG_W),
	localparam int Y_W = $clog2(IMG_H),
	localparam int A_W = $clog2(IMG_W * IMG_H)
) (
	input wire clk,
	input wire reset,
	input wire cap_valid,
	input wire integral_pkg::grey_t cap_grey,
	input wire [X_W-1:0] cap_x,
	input wire [Y_W-1:0] cap_y,
	input wire cap_last,
	output logic int_we,
	output logic [A_W-1:0] int_addr,
	output integral_pkg::sum_t int_data,
	output logic done
);

	// stage 1, one edge after cap_valid
	logic s1_valid;
	logic s1_row0;
	logic s1_last;
	logic [X_W-1:0] s1_x;
	logic [A_W-1:0] s1_addr;

	// sum of current row up to and incl. s1_x
	integral_pkg::sum_t row_sum;
	// previous row integral at s1_x
	integral_pkg::sum_t prev_sum;
	integral_pkg::sum_t int_sum;

	////////////////////////////////////////
	// line buffer, previous row of sums
	////////////////////////////////////////

	// read addressed straight from cap_x, data lands with stage 1
	// write of column x trails the read of x by a full row
	sdp_ram #(
		.payload_t(integral_pkg::sum_t),
		.DEPTH(IMG_W)
	) u_line_buf (
		.clk(clk),
		.we(s1_valid),
		.wr_addr(s1_x),
		.wr_data(int_sum),
		.rd_addr(cap_x),
		.rd_data(prev_sum)
	);

	// row 0 has nothing above, buffer holds stale data there
	assign int_sum = row_sum + (s1_row0 ? '0 : prev_sum);

	// write stream to integral store
	assign int_we = s1_valid;
	assign int_addr = s1_addr;
	assign int_data = int_sum;

	////////////////////////////////////////
	// pipeline control
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			s1_valid <= cap_valid;
			// pulse as the last sum goes out
			done <= s1_valid && s1_last;
		end
	end

	// stage 1 payload
	always_ff @(posedge clk) begin
		if (cap_valid) begin
			// running row sum restarts at column 0
			if (cap_x == '0) begin
				row_sum <= integral_pkg::sum_t'(cap_grey);
			end else begin
				row_sum <= row_sum + integral_pkg::sum_t'(cap_grey);
			end
			s1_x <= cap_x;
			s1_row0 <= (cap_y == '0);
			s1_last <= cap_last;
			// linear address row * width + column
			s1_addr <= A_W'(cap_y) * A_W'(IMG_W) + A_W'(cap_x);
		end
	end

endmodule

`default_nettype wire

//--- src/integral_top.sv
`timescale 1ns/1ps
`default_nettype none

module integral_top #(
	parameter int IMG_W = integral_pkg::DEF_IMG_W,
	parameter int IMG_H = integral_pkg::DEF_IMG_H,
	localparam int A_W = $clog2(IMG_W * IMG_H)
) (
	input wire clk,
	input wire reset,
	input wire arm,
	input wire pix_valid,
	input wire integral_pkg::rgb_t pix_rgb,
	input wire pix_sof,
	input wire [A_W-1:0] rd_addr,
	output logic busy,
	output logic done,
	output integral_pkg::grey_t rd_grey,
	output integral_pkg::sum_t rd_sum
);

	localparam int X_W = $clog2(IMG_W);
	localparam int Y_W = $clog2(IMG_H);

	// capture to engine
	logic cap_valid;
	integral_pkg::grey_t cap_grey;
	logic [X_W-1:0] cap_x;
	logic [Y_W-1:0] cap_y;
	logic cap_last;

	// capture to source store
	logic src_we;
	logic [A_W-1:0] src_addr;
	integral_pkg::grey_t src_data;

	// engine to integral store
	logic int_we;
	logic [A_W-1:0] int_addr;
	integral_pkg::sum_t int_data;

	////////////////////////////////////////
	// capture and integral pipeline
	////////////////////////////////////////

	frame_capture #(
		.IMG_W(IMG_W),
		.IMG_H(IMG_H)
	) u_capture (
		.clk(clk),
		.reset(reset),
		.arm(arm),
		.pix_valid(pix_valid),
		.pix_rgb(pix_rgb),
		.pix_sof(pix_sof),
		.busy(busy),
		.cap_valid(cap_valid),
		.cap_grey(cap_grey),
		.cap_x(cap_x),
		.cap_y(cap_y),
		.cap_last(cap_last),
		.src_we(src_we),
		.src_addr(src_addr),
		.src_data(src_data)
	);

	integral_engine #(
		.IMG_W(IMG_W),
		.IMG_H(IMG_H)
	) u_engine (
		.clk(clk),
		.reset(reset),
		.cap_valid(cap_valid),
		.cap_grey(cap_grey),
		.cap_x(cap_x),
		.cap_y(cap_y),
		.cap_last(cap_last),
		.int_we(int_we),
		.int_addr(int_addr),
		.int_data(int_data),
		.done(done)
	);

	////////////////////////////////////////
	// frame stores, shared read address
	////////////////////////////////////////

	// grey frame
	sdp_ram #(
		.payload_t(integral_pkg::grey_t),
		.DEPTH(IMG_W * IMG_H)
	) u_src_store (
		.clk(clk),
		.we(src_we),
		.wr_addr(src_addr),
		.wr_data(src_data),
		.rd_addr(rd_addr),
		.rd_data(rd_grey)
	);

	// integral image
	sdp_ram #(
		.payload_t(integral_pkg::sum_t),
		.DEPTH(IMG_W * IMG_H)
	) u_int_store (
		.clk(clk),
		.we(int_we),
		.wr_addr(int_addr),
		.wr_data(int_data),
		.rd_addr(rd_addr),
		.rd_data(rd_sum)
	);

endmodule

`default_nettype wire

//--- verif/integral_assert.sv
`timescale 1ns/1ps
`default_nettype none

// control checks bound to integral_top
module integral_assert (
	input wire clk,
	input wire reset,
	input wire busy,
	input wire done
);

	// failed assertions so far
	int fail_count = 0;

	////////////////////////////////////////
	// done pulse shape
	////////////////////////////////////////

	// one cycle only
	done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else begin
			$error("done stayed high for two cycles");
			fail_count++;
		end

	// quiet in the first cycle out of reset
	reset_quiet: assert property (@(posedge clk) $fell(reset) |-> !busy && !done)
		else begin
			$error("busy or done high right after reset release");
			fail_count++;
		end

	// done two edges after busy fell at the accept edge
	done_after_busy: assert property (@(posedge clk) disable iff (reset)
		done |-> $past(busy, 3) && !$past(busy, 2))
		else begin
			$error("done pulse not two edges after busy fell");
			fail_count++;
		end

endmodule

`default_nettype wire

//--- verif/integral_tb.sv
`timescale 1ns/1ps
`default_nettype none

module integral_tb;

	localparam int IMG_W = 16;
	localparam int IMG_H = 12;
	localparam int N_PIX = IMG_W * IMG_H;
	localparam int A_W = $clog2(N_PIX);
	// cycles allowed for any single wait
	localparam int TIMEOUT = 200;

	logic clk;
	logic reset;
	logic arm;
	logic pix_valid;
	integral_pkg::rgb_t pix_rgb;
	logic pix_sof;
	logic [A_W-1:0] rd_addr;
	logic busy;
	logic done;
	integral_pkg::grey_t rd_grey;
	integral_pkg::sum_t rd_sum;

	// frame model and expected stores
	integral_pkg::rgb_t frame [N_PIX];
	integral_pkg::grey_t exp_grey [N_PIX];
	integral_pkg::sum_t exp_sum [N_PIX];
	// last readback and a saved earlier copy
	integral_pkg::grey_t snap_grey [N_PIX];
	integral_pkg::sum_t snap_sum [N_PIX];
	integral_pkg::grey_t prev_grey [N_PIX];
	integral_pkg::sum_t prev_sum [N_PIX];

	int errors;
	int test_errors;
	int tests_run;
	int done_count = 0;

	integral_top #(
		.IMG_W(IMG_W),
		.IMG_H(IMG_H)
	) UUT (
		.clk(clk),
		.reset(reset),
		.arm(arm),
		.pix_valid(pix_valid),
		.pix_rgb(pix_rgb),
		.pix_sof(pix_sof),
		.rd_addr(rd_addr),
		.busy(busy),
		.done(done),
		.rd_grey(rd_grey),
		.rd_sum(rd_sum)
	);

	bind integral_top integral_assert u_assert (
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.done(done)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// done pulses seen since reset
	always @(posedge clk) begin
		if (!reset && done) begin
			done_count <= done_count + 1;
		end
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// zero extended red + green + blue
	function automatic integral_pkg::grey_t field_sum(input integral_pkg::rgb_t c);
		return {5'd0, c.red} + {5'd0, c.green} + {6'd0, c.blue};
	endfunction

	task automatic fill_random();
		for (int i = 0; i < N_PIX; i++) begin
			frame[i] = 8'($urandom);
		end
	endtask

	// brute force rectangle sums from the origin
	task automatic build_model();
		integral_pkg::sum_t acc;
		for (int i = 0; i < N_PIX; i++) begin
			exp_grey[i] = field_sum(frame[i]);
		end
		for (int y = 0; y < IMG_H; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				acc = '0;
				for (int r = 0; r <= y; r++) begin
					for (int c = 0; c <= x; c++) begin
						acc = acc + integral_pkg::sum_t'(exp_grey[r * IMG_W + c]);
					end
				end
				exp_sum[y * IMG_W + x] = acc;
			end
		end
	endtask

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic compare_grey(input integral_pkg::grey_t got, input integral_pkg::grey_t exp,
		input int addr);
		if (got !== exp) begin
			$display("mismatch at %0t: grey at address %0d is %0d, expected %0d",
				$time, addr, got, exp);
			test_errors++;
		end
	endtask

	task automatic compare_sum(input integral_pkg::sum_t got, input integral_pkg::sum_t exp,
		input int addr);
		if (got !== exp) begin
			$display("mismatch at %0t: sum at address %0d is %0d, expected %0d",
				$time, addr, got, exp);
			test_errors++;
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic pulse_arm();
		int cycles;
		@(negedge clk);
		arm = 1'b1;
		@(negedge clk);
		arm = 1'b0;
		cycles = 0;
		while (!busy && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!busy) begin
			$display("timeout: busy did not rise after the arm pulse");
			test_errors++;
		end
	endtask

	// stray pixels outside the frame
	task automatic send_junk(input int count, input bit sof);
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			pix_valid = 1'b1;
			pix_rgb = 8'($urandom);
			pix_sof = sof;
		end
		@(negedge clk);
		pix_valid = 1'b0;
		pix_sof = 1'b0;
	endtask

	// model frame in raster order with optional idle gaps and a stray arm
	task automatic send_frame(input int max_gap, input bit arm_mid);
		int gap;
		for (int i = 0; i < N_PIX; i++) begin
			gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
			repeat (gap) begin
				@(negedge clk);
				pix_valid = 1'b0;
				pix_sof = 1'b0;
			end
			@(negedge clk);
			if (!busy) begin
				$display("busy was low before pixel %0d of the frame", i);
				test_errors++;
			end
			pix_valid = 1'b1;
			pix_rgb = frame[i];
			pix_sof = (i == 0);
			arm = arm_mid && (i == N_PIX / 2);
		end
		@(negedge clk);
		pix_valid = 1'b0;
		pix_sof = 1'b0;
		arm = 1'b0;
		// busy drops with the last pixel
		if (busy) begin
			$display("busy still high after the last pixel was accepted");
			test_errors++;
		end
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (!done && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout: no done pulse within %0d cycles of the last pixel", TIMEOUT);
			test_errors++;
		end
	endtask

	// arm then junk then frame, exactly one done expected
	task automatic run_capture(input int max_gap, input bit arm_mid, input int junk);
		int done_before;
		done_before = done_count;
		pulse_arm();
		if (junk > 0) begin
			send_junk(junk, 1'b0);
		end
		send_frame(max_gap, arm_mid);
		wait_done();
		repeat (3) @(negedge clk);
		if (done_count != done_before + 1) begin
			$display("expected one done pulse for the frame, saw %0d", done_count - done_before);
			test_errors++;
		end
	endtask

	// read every address of both stores
	task automatic check_stores();
		for (int i = 0; i < N_PIX; i++) begin
			@(negedge clk);
			rd_addr = A_W'(i);
			@(negedge clk);
			compare_grey(rd_grey, exp_grey[i], i);
			compare_sum(rd_sum, exp_sum[i], i);
			snap_grey[i] = rd_grey;
			snap_sum[i] = rd_sum;
		end
	endtask

	task automatic report_test(input string name);
		$display("%s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed", test_errors);
		errors += test_errors;
		test_errors = 0;
		tests_run++;
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic test_grey_conversion();
		fill_random();
		// brightest and darkest corners
		frame[0] = 8'hff;
		frame[N_PIX - 1] = 8'h00;
		build_model();
		run_capture(0, 1'b0, 0);
		check_stores();
		report_test("grey conversion");
	endtask

	task automatic test_integral_values();
		fill_random();
		build_model();
		run_capture(0, 1'b0, 0);
		check_stores();
		report_test("integral values");
	endtask

	task automatic test_frame_alignment();
		fill_random();
		build_model();
		// sent while idle so dropped even with sof
		send_junk(10, 1'b1);
		run_capture(0, 1'b0, 7);
		check_stores();
		report_test("frame alignment");
	endtask

	task automatic test_strobe_spacing();
		fill_random();
		build_model();
		run_capture(0, 1'b0, 0);
		check_stores();
		for (int i = 0; i < N_PIX; i++) begin
			prev_grey[i] = snap_grey[i];
			prev_sum[i] = snap_sum[i];
		end
		run_capture(3, 1'b0, 0);
		check_stores();
		// gapped readback against back-to-back readback
		for (int i = 0; i < N_PIX; i++) begin
			compare_grey(snap_grey[i], prev_grey[i], i);
			compare_sum(snap_sum[i], prev_sum[i], i);
		end
		report_test("strobe spacing");
	endtask

	task automatic test_rearm();
		fill_random();
		build_model();
		// stray arm halfway through
		run_capture(0, 1'b1, 0);
		check_stores();
		// second frame must overwrite everything
		fill_random();
		build_model();
		run_capture(2, 1'b0, 0);
		check_stores();
		report_test("re-arm");
	endtask

	initial begin
		void'($urandom(85065));
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		clk = 1'b0;
		reset = 1'b1;
		arm = 1'b0;
		pix_valid = 1'b0;
		pix_rgb = '0;
		pix_sof = 1'b0;
		rd_addr = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_grey_conversion();
		test_integral_values();
		test_frame_alignment();
		test_strobe_spacing();
		test_rearm();

		$display("%0d tests run, %0d errors, %0d assertion failures", tests_run, errors,
			UUT.u_assert.fail_count);
		if (errors == 0 && UUT.u_assert.fail_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
src/integral_pkg.sv
src/sdp_ram.sv
src/frame_capture.sv
src/integral_engine.sv
src/integral_top.sv
verif/integral_assert.sv
verif/integral_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= integral_tb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SOURCES := $(wildcard src/*.sv verif/*.sv)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the log, not from the exit status
run: compile
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
